// ==== verif/mic_stim.txt ====
# id src hold spk_en mic0 mic1 mic2 exp_monitor frames
# src 0 silence 1 tone_a 2 tone_b 3 mic 4 decim, words and exp in hex
1  3 0 3 1234 abcd 5a5a 1234 2
2  3 0 2 8000 7fff 0001 8000 2
# hold keeps the previous word
3  3 1 1 4000 1111 2222 8000 2
4  3 0 3 c000 3333 4444 c000 2
# decimator, one frame per line, pairs counted from reset
5  4 0 3 7ffe 0f0f f0f0 c000 1
6  4 0 3 7fff 00ff ff00 7ffe 1
7  4 0 3 8001 aaaa 5555 7ffe 1
8  4 0 3 ffff 5555 aaaa c000 1
9  4 0 3 0003 1357 2468 c000 1
10 4 0 3 fffe 8642 9753 0000 1
# tones, exp unused
11 1 0 3 1111 2222 3333 0000 3
12 2 0 3 2222 3333 4444 0000 3
# silence and speaker gating
13 0 0 3 5555 6666 7777 0000 2
14 3 0 0 0000 ffff 8000 0000 2
15 3 0 1 7fff 0000 ffff 7fff 2

// ==== all.f ====
source/mic_pkg.sv
source/i2s_receiver.sv
source/sine_generator.sv
source/pair_decimator.sv
source/playback_path.sv
source/pdm_modulator.sv
source/mic_array_top.sv
verif/tb_mic_array.sv

// ==== Bender.yml ====
package:
  name: mic_array

sources:
  # package first, then the leaf modules and the top level
  - source/mic_pkg.sv
  - source/i2s_receiver.sv
  - source/sine_generator.sv
  - source/pair_decimator.sv
  - source/playback_path.sv
  - source/pdm_modulator.sv
  - source/mic_array_top.sv

  # testbench, top module tb_mic_array
  - target: test
    files:
      - verif/tb_mic_array.sv

export_include_dirs: []

dependencies: {}

frozen: false

// ==== verif/tb_mic_array.sv ====
`timescale 1ns/1ps

module tb_mic_array;

  localparam int MAX_TESTS    = 32;
  localparam int FRAME_CYCLES = 2 * mic_pkg::SLOT_BITS * 2 * mic_pkg::BCLK_HALF;

  logic                  audio_clk;
  logic                  rst_n;
  logic [2:0]            mic_data;
  mic_pkg::play_cfg_t    cfg;
  logic [2:0]            mic_bclk;
  logic [2:0]            mic_lrcl;
  logic signed [15:0]    monitor;
  logic                  spk_l;
  logic                  spk_r;

  // test table from the stimulus file
  int          t_src    [MAX_TESTS];
  int          t_hold   [MAX_TESTS];
  int          t_spk    [MAX_TESTS];
  int          t_frames [MAX_TESTS];
  logic [15:0] t_word   [MAX_TESTS][3];
  logic [15:0] t_exp    [MAX_TESTS];
  int          num_tests;
  int          total_frames;
  int          cycle_limit;
  int          cycles;
  int          errors;
  int          checks;

  // microphone models
  logic [31:0] lcg_state;
  logic [15:0] cur_word [3];
  logic [15:0] shadow   [3];
  int          pos      [3];
  int          bclk_last[3];
  int          lrcl_last[3];
  logic [2:0]  prev_bclk;
  logic [2:0]  prev_lrcl;

  int          ones_l;
  int          ones_r;
  int          win_cycles;
  logic        frame_end;
  logic        tone_check_en;
  logic [31:0] tone_incr;

  mic_array_top i_dut (
    .audio_clk (audio_clk),
    .rst_n     (rst_n),
    .mic_data  (mic_data),
    .cfg       (cfg),
    .mic_bclk  (mic_bclk),
    .mic_lrcl  (mic_lrcl),
    .monitor   (monitor),
    .spk_l     (spk_l),
    .spk_r     (spk_r)
  );

  initial begin
    audio_clk = 1'b0;
    forever #50 audio_clk = ~audio_clk;
  end

  // watchdog on the cycle count of the test run
  initial begin
    wait (cycle_limit > 0 && cycles > cycle_limit);
    $display("timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("tests failed");
    $finish;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // reference sine table entry round(127 * sin(2*pi*i/64))
  function automatic logic [7:0] sine_ref(input int idx);
    real r;
    int  v;
    r = 127.0 * $sin(2.0 * 3.14159265358979 * idx / 64.0);
    v = (r >= 0.0) ? $rtoi(r + 0.5) : -$rtoi(-r + 0.5);
    return v[7:0];
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s: got %h, expected %h at cycle %0d", name, got, exp, cycles);
    end
  endtask

  // ones in the window must lie within 1 of n*u/65536
  task automatic check_density(input string name, input int ones, input logic en,
                               input int u, input int n);
    int   dev;
    logic ok;
    dev = ones * 65536 - n * u;
    ok  = (dev <= 65536) && (dev >= -65536);
    if (!en) begin
      check_value({name, " ones while disabled"}, ones, 0);
    end else begin
      check_value({name, " density in range"}, ok, 1);
    end
  endtask

  task automatic load_stim();
    int          fd;
    int          n;
    int          id;
    int          src;
    int          hold;
    int          spk;
    int          frames;
    logic [15:0] w0;
    logic [15:0] w1;
    logic [15:0] w2;
    logic [15:0] exp;
    string       line;
    fd = $fopen("verif/mic_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file verif/mic_stim.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        n = $sscanf(line, "%d %d %d %d %h %h %h %h %d",
                    id, src, hold, spk, w0, w1, w2, exp, frames);
        if (n == 9 && num_tests < MAX_TESTS) begin
          t_src[num_tests]     = src;
          t_hold[num_tests]    = hold;
          t_spk[num_tests]     = spk;
          t_word[num_tests][0] = w0;
          t_word[num_tests][1] = w1;
          t_word[num_tests][2] = w2;
          t_exp[num_tests]     = exp;
          t_frames[num_tests]  = frames;
          total_frames += frames;
          num_tests++;
        end
      end
      $fclose(fd);
    end
  endtask

  // one audio_clk cycle of rate checks, speaker counts, mic shifting and tone check
  task automatic step_cycle();
    logic [31:0] phase;
    logic [15:0] exp_tone;
    @(negedge audio_clk);
    cycles++;
    frame_end  = 1'b0;
    ones_l     += spk_l;
    ones_r     += spk_r;
    win_cycles++;
    for (int k = 0; k < 3; k++) begin
      if (mic_bclk[k] != prev_bclk[k]) begin
        if (bclk_last[k] >= 0) begin
          check_value("mic_bclk half period", cycles - bclk_last[k], mic_pkg::BCLK_HALF);
        end
        bclk_last[k] = cycles;
      end
      if (mic_lrcl[k] != prev_lrcl[k]) begin
        if (lrcl_last[k] >= 0) begin
          check_value("mic_lrcl half period", cycles - lrcl_last[k],
                      mic_pkg::SLOT_BITS * 2 * mic_pkg::BCLK_HALF);
        end
        lrcl_last[k] = cycles;
      end
      // shift out after each falling bclk with a one-bit delay after lrcl falls
      if (prev_bclk[k] && !mic_bclk[k]) begin
        if (prev_lrcl[k] && !mic_lrcl[k]) begin
          pos[k] = 0;
          if (k == 0) frame_end = 1'b1;
        end else begin
          pos[k]++;
        end
        if (pos[k] == 1) shadow[k] = cur_word[k];
        lcg_state = lcg_next(lcg_state);
        if (pos[k] >= 1 && pos[k] <= 16) begin
          mic_data[k] = shadow[k][16 - pos[k]];
        end else begin
          mic_data[k] = lcg_state[16];
        end
      end
      prev_bclk[k] = mic_bclk[k];
      prev_lrcl[k] = mic_lrcl[k];
    end
    // mid-tick sample of the tone
    if (tone_check_en && (cycles % mic_pkg::TONE_TICK_DIV == 256)) begin
      phase    = (cycles / mic_pkg::TONE_TICK_DIV) * tone_incr;
      exp_tone = {sine_ref(phase[31:26]), 8'h00};
      check_value("monitor tone", $unsigned(monitor), exp_tone);
    end
  endtask

  task automatic wait_frame();
    do begin
      step_cycle();
    end while (!frame_end);
  endtask

  initial begin
    int          mic_count;
    int          prev_s;
    int          cur_s;
    int          exp_decim;
    int          u;
    logic [15:0] exp_monitor;
    logic        pair_done;
    mic_pkg::play_src_t src;
    rst_n = 1'b0;
    mic_data = '0;
    cfg = '0;
    lcg_state = 32'd1;
    num_tests = 0;
    total_frames = 0;
    cycle_limit = 0;
    cycles = 0;
    errors = 0;
    checks = 0;
    mic_count = 0;
    prev_s = 0;
    exp_decim = 0;
    exp_monitor = '0;
    prev_bclk = '0;
    prev_lrcl = '0;
    tone_check_en = 1'b0;
    tone_incr = '0;
    for (int k = 0; k < 3; k++) begin
      pos[k] = 0;
      bclk_last[k] = -1;
      lrcl_last[k] = -1;
      cur_word[k] = '0;
      shadow[k] = '0;
    end
    load_stim();
    if (num_tests == 0) begin
      $display("no test lines were read from the stimulus file");
      errors++;
    end
    cycle_limit = FRAME_CYCLES * total_frames + 4096;
    repeat (2) @(negedge audio_clk);
    rst_n = 1'b1;
    for (int t = 0; t < num_tests; t++) begin
      src = mic_pkg::play_src_t'(t_src[t]);
      cfg.src = src;
      cfg.hold = t_hold[t][0];
      cfg.spk_en = t_spk[t][1:0];
      for (int k = 0; k < 3; k++) cur_word[k] = t_word[t][k];
      tone_check_en = (src == mic_pkg::src_tone_a) || (src == mic_pkg::src_tone_b);
      tone_incr = (src == mic_pkg::src_tone_a) ? mic_pkg::TONE_A_INCR : mic_pkg::TONE_B_INCR;
      for (int f = 0; f < t_frames[t]; f++) begin
        ones_l = 0;
        ones_r = 0;
        win_cycles = 0;
        wait_frame();
        // mics 1 and 2 are only visible inside the top level
        check_value("mic_sample[1].data", $unsigned(i_dut.mic_sample[1].data), t_word[t][1]);
        check_value("mic_sample[2].data", $unsigned(i_dut.mic_sample[2].data), t_word[t][2]);
        // pairs of mic 0 words counted from reset
        cur_s = $signed(t_word[t][0]);
        mic_count++;
        pair_done = (mic_count % 2 == 0);
        if (pair_done) exp_decim = (prev_s + cur_s) >>> 1;
        prev_s = cur_s;
        if (src == mic_pkg::src_mic) begin
          if (!cfg.hold) exp_monitor = t_word[t][0];
          check_value("monitor mic", $unsigned(monitor), exp_monitor);
        end
        if (src == mic_pkg::src_decim && pair_done) begin
          check_value("monitor decim", $unsigned(monitor), exp_decim[15:0]);
        end
        if (f >= 1 && (src == mic_pkg::src_mic || src == mic_pkg::src_silence)) begin
          u = (src == mic_pkg::src_silence) ? 32768 : int'(t_word[t][0] ^ 16'h8000);
          check_density("spk_l", ones_l, cfg.spk_en[1], u, win_cycles);
          check_density("spk_r", ones_r, cfg.spk_en[0], u, win_cycles);
        end
      end
      if (!tone_check_en) begin
        check_value("monitor end of test", $unsigned(monitor), t_exp[t]);
      end
    end
    $display("errors: %0d in %0d checks over %0d tests", errors, checks, num_tests);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== source/mic_array_top.sv ====
`timescale 1ns/1ps

module mic_array_top (
  input  logic                                audio_clk,
  input  logic                                rst_n,
  input  logic [mic_pkg::NUM_MICS-1:0]        mic_data,
  input  mic_pkg::play_cfg_t                  cfg,
  output logic [mic_pkg::NUM_MICS-1:0]        mic_bclk,
  output logic [mic_pkg::NUM_MICS-1:0]        mic_lrcl,
  output logic signed [mic_pkg::SAMPLE_W-1:0] monitor,
  output logic                                spk_l,
  output logic                                spk_r
);

  mic_pkg::sample_t                    mic_sample [mic_pkg::NUM_MICS];
  mic_pkg::sample_t                    decim_sample;
  logic signed [mic_pkg::TONE_W-1:0]   tone_a;
  logic signed [mic_pkg::TONE_W-1:0]   tone_b;
  logic signed [mic_pkg::SAMPLE_W-1:0] level;
  logic                                pdm;

  // one receiver per microphone, each with its own clocks
  for (genvar k = 0; k < mic_pkg::NUM_MICS; k++) begin : g_rx
    i2s_receiver i_rx (
      .audio_clk (audio_clk),
      .rst_n     (rst_n),
      .mic_data  (mic_data[k]),
      .bclk      (mic_bclk[k]),
      .lrcl      (mic_lrcl[k]),
      .sample    (mic_sample[k])
    );
  end

  sine_generator #(.PHASE_INCR(mic_pkg::TONE_A_INCR)) i_tone_a (
    .audio_clk (audio_clk),
    .rst_n     (rst_n),
    .tone      (tone_a)
  );

  sine_generator #(.PHASE_INCR(mic_pkg::TONE_B_INCR)) i_tone_b (
    .audio_clk (audio_clk),
    .rst_n     (rst_n),
    .tone      (tone_b)
  );

  // anti-alias and rate halving for mic 0
  pair_decimator i_decim (
    .audio_clk  (audio_clk),
    .rst_n      (rst_n),
    .in_sample  (mic_sample[0]),
    .out_sample (decim_sample)
  );

  playback_path i_play (
    .audio_clk    (audio_clk),
    .rst_n        (rst_n),
    .cfg          (cfg),
    .mic_sample   (mic_sample[0]),
    .decim_sample (decim_sample),
    .tone_a       (tone_a),
    .tone_b       (tone_b),
    .pdm          (pdm),
    .level        (level),
    .monitor      (monitor),
    .spk_l        (spk_l),
    .spk_r        (spk_r)
  );

  pdm_modulator i_pdm (
    .audio_clk (audio_clk),
    .rst_n     (rst_n),
    .level     (level),
    .pdm       (pdm)
  );

endmodule

// ==== source/pdm_modulator.sv ====
`timescale 1ns/1ps

module pdm_modulator (
  input  logic                                audio_clk,
  input  logic                                rst_n,
  input  logic signed [mic_pkg::SAMPLE_W-1:0] level,
  output logic                                pdm
);

  logic [mic_pkg::SAMPLE_W-1:0] level_u;
  logic [mic_pkg::SAMPLE_W:0]   acc;

  // offset binary, the same as adding 32768
  assign level_u = {~level[mic_pkg::SAMPLE_W-1], level[mic_pkg::SAMPLE_W-2:0]};

  // residue feeds back, the carry is the output bit
  always_ff @(posedge audio_clk or negedge rst_n) begin
    if (!rst_n) begin
      acc <= '0;
    end else begin
      acc <= {1'b0, acc[mic_pkg::SAMPLE_W-1:0]} + {1'b0, level_u};
    end
  end

  assign pdm = acc[mic_pkg::SAMPLE_W];

  // a full-scale negative level never produces a one
  a_pdm_floor: assert property (
    @(posedge audio_clk) disable iff (!rst_n)
    (level == {1'b1, {(mic_pkg::SAMPLE_W-1){1'b0}}}) [*2] |=> !pdm
  );

endmodule

// ==== source/playback_path.sv ====
`timescale 1ns/1ps

module playback_path (
  input  logic                                audio_clk,
  input  logic                                rst_n,
  input  mic_pkg::play_cfg_t                  cfg,
  input  mic_pkg::sample_t                    mic_sample,
  input  mic_pkg::sample_t                    decim_sample,
  input  logic signed [mic_pkg::TONE_W-1:0]   tone_a,
  input  logic signed [mic_pkg::TONE_W-1:0]   tone_b,
  input  logic                                pdm,
  output logic signed [mic_pkg::SAMPLE_W-1:0] level,
  output logic signed [mic_pkg::SAMPLE_W-1:0] monitor,
  output logic                                spk_l,
  output logic                                spk_r
);

  logic signed [mic_pkg::SAMPLE_W-1:0] tone_a_wide;
  logic signed [mic_pkg::SAMPLE_W-1:0] tone_b_wide;
  logic signed [mic_pkg::SAMPLE_W-1:0] sel_value;
  logic                                sel_load;

  // tone in the top byte keeps its sign as the sample sign
  assign tone_a_wide = {tone_a, {(mic_pkg::SAMPLE_W - mic_pkg::TONE_W){1'b0}}};
  assign tone_b_wide = {tone_b, {(mic_pkg::SAMPLE_W - mic_pkg::TONE_W){1'b0}}};

  always_comb begin
    sel_value = '0;
    sel_load  = 1'b1;
    case (cfg.src)
      mic_pkg::src_tone_a: sel_value = tone_a_wide;
      mic_pkg::src_tone_b: sel_value = tone_b_wide;
      mic_pkg::src_mic: begin
        sel_value = mic_sample.data;
        sel_load  = mic_sample.valid;
      end
      mic_pkg::src_decim: begin
        sel_value = decim_sample.data;
        sel_load  = decim_sample.valid;
      end
      default: sel_value = '0;
    endcase
  end

  always_ff @(posedge audio_clk or negedge rst_n) begin
    if (!rst_n) begin
      level   <= '0;
      monitor <= '0;
    end else begin
      if (sel_load) begin
        level <= sel_value;
      end
      if (!cfg.hold) begin
        monitor <= level;
      end
    end
  end

  assign spk_l = cfg.spk_en[1] & pdm;
  assign spk_r = cfg.spk_en[0] & pdm;

endmodule

// ==== source/pair_decimator.sv ====
`timescale 1ns/1ps

module pair_decimator (
  input  logic             audio_clk,
  input  logic             rst_n,
  input  mic_pkg::sample_t in_sample,
  output mic_pkg::sample_t out_sample
);

  logic signed [mic_pkg::SAMPLE_W-1:0] first_q;
  logic signed [mic_pkg::SAMPLE_W:0]   pair_sum;
  logic signed [mic_pkg::SAMPLE_W-1:0] avg_q;
  logic                                second;
  logic                                valid_q;

  // one extra bit so the sum cannot wrap
  assign pair_sum = first_q + in_sample.data;

  always_ff @(posedge audio_clk or negedge rst_n) begin
    if (!rst_n) begin
      second  <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= in_sample.valid & second;
      if (in_sample.valid) begin
        second <= ~second;
      end
    end
  end

  always_ff @(posedge audio_clk) begin
    if (in_sample.valid && !second) begin
      first_q <= in_sample.data;
    end
    // dropping the low bit floors the average
    if (in_sample.valid && second) begin
      avg_q <= pair_sum[mic_pkg::SAMPLE_W:1];
    end
  end

  assign out_sample.valid = valid_q;
  assign out_sample.data  = avg_q;

  a_out_after_in: assert property (
    @(posedge audio_clk) disable iff (!rst_n)
    out_sample.valid |-> $past(in_sample.valid)
  );

endmodule

// ==== source/sine_generator.sv ====
`timescale 1ns/1ps

module sine_generator #(
  parameter logic [mic_pkg::PHASE_W-1:0] PHASE_INCR = mic_pkg::TONE_A_INCR
) (
  input  logic                              audio_clk,
  input  logic                              rst_n,
  output logic signed [mic_pkg::TONE_W-1:0] tone
);

  logic [$clog2(mic_pkg::TONE_TICK_DIV)-1:0] tick_cnt;
  logic [mic_pkg::PHASE_W-1:0]               phase;
  logic                                      tick;

  // 64 entries folded onto a quarter wave, round(127 * sin(2*pi*i/64))
  function automatic logic signed [mic_pkg::TONE_W-1:0] sine_entry(input logic [5:0] idx);
    logic [4:0]                       k;
    logic [6:0]                       mag;
    logic signed [mic_pkg::TONE_W-1:0] val;
    k = (idx[4:0] > 5'd16) ? 5'(6'd32 - {1'b0, idx[4:0]}) : idx[4:0];
    case (k)
      5'd0:    mag = 7'd0;
      5'd1:    mag = 7'd12;
      5'd2:    mag = 7'd25;
      5'd3:    mag = 7'd37;
      5'd4:    mag = 7'd49;
      5'd5:    mag = 7'd60;
      5'd6:    mag = 7'd71;
      5'd7:    mag = 7'd81;
      5'd8:    mag = 7'd90;
      5'd9:    mag = 7'd98;
      5'd10:   mag = 7'd106;
      5'd11:   mag = 7'd112;
      5'd12:   mag = 7'd117;
      5'd13:   mag = 7'd122;
      5'd14:   mag = 7'd125;
      5'd15:   mag = 7'd126;
      default: mag = 7'd127;
    endcase
    val = {1'b0, mag};
    // second half of the period is negative
    return idx[5] ? -val : val;
  endfunction

  assign tick = (tick_cnt == mic_pkg::TONE_TICK_DIV - 1);

  always_ff @(posedge audio_clk or negedge rst_n) begin
    if (!rst_n) begin
      tick_cnt <= '0;
      phase    <= '0;
      tone     <= '0;
    end else begin
      tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
      if (tick) begin
        phase <= phase + PHASE_INCR;
      end
      tone <= sine_entry(phase[mic_pkg::PHASE_W-1 -: 6]);
    end
  end

endmodule

// ==== source/i2s_receiver.sv ====
`timescale 1ns/1ps

module i2s_receiver (
  input  logic             audio_clk,
  input  logic             rst_n,
  input  logic             mic_data,
  output logic             bclk,
  output logic             lrcl,
  output mic_pkg::sample_t sample
);

  logic [$clog2(mic_pkg::BCLK_HALF)-1:0]   div_cnt;
  logic [$clog2(2*mic_pkg::SLOT_BITS)-1:0] bit_cnt;
  logic [mic_pkg::SAMPLE_W-2:0]            shift_q;
  logic signed [mic_pkg::SAMPLE_W-1:0]     data_q;
  logic                                    valid_q;
  logic                                    half_done;
  logic                                    bclk_rise;
  logic                                    bclk_fall;
  logic                                    in_word;
  logic                                    last_bit;

  assign half_done = (div_cnt == mic_pkg::BCLK_HALF - 1);
  assign bclk_rise = half_done & ~bclk;
  assign bclk_fall = half_done & bclk;

  // rising edge 0 of the frame is the one-bit delay, data follows MSB first
  assign in_word  = (bit_cnt >= 1) && (bit_cnt <= mic_pkg::SAMPLE_W);
  assign last_bit = bclk_rise && (bit_cnt == mic_pkg::SAMPLE_W);

  // clock generation and frame position
  always_ff @(posedge audio_clk or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt <= '0;
      bit_cnt <= '0;
      bclk    <= 1'b0;
      lrcl    <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= last_bit;
      if (half_done) begin
        div_cnt <= '0;
        bclk    <= ~bclk;
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
      if (bclk_rise) begin
        bit_cnt <= bit_cnt + 1'b1;
      end
      // word select changes on the falling bclk edge, high for the right slot
      if (bclk_fall) begin
        lrcl <= bit_cnt[$high(bit_cnt)];
      end
    end
  end

  // left slot shift register
  always_ff @(posedge audio_clk) begin
    if (bclk_rise && in_word) begin
      shift_q <= {shift_q[mic_pkg::SAMPLE_W-3:0], mic_data};
    end
    if (last_bit) begin
      data_q <= {shift_q, mic_data};
    end
  end

  assign sample.valid = valid_q;
  assign sample.data  = data_q;

  // one strobe per frame, never a stretched pulse
  a_valid_single: assert property (
    @(posedge audio_clk) disable iff (!rst_n)
    sample.valid |=> !sample.valid
  );

endmodule

// ==== source/mic_pkg.sv ====
package mic_pkg;

  // array and sample geometry
  localparam int NUM_MICS = 3;
  localparam int SAMPLE_W = 16;
  localparam int TONE_W   = 8;

  // i2s clocking
  // half bclk period in audio_clk cycles, slot length in bit clocks
  localparam int BCLK_HALF = 16;
  localparam int SLOT_BITS = 32;

  // tone stepping
  localparam int TONE_TICK_DIV = 512;
  localparam int PHASE_W       = 32;

  // 750 Hz and 440 Hz with a 192 kHz phase tick
  localparam logic [PHASE_W-1:0] TONE_A_INCR = 32'h0100_0000;
  localparam logic [PHASE_W-1:0] TONE_B_INCR = 32'h0096_2fc9;

  // one audio word with its strobe
  typedef struct packed {
    logic                       valid;
    logic signed [SAMPLE_W-1:0] data;
  } sample_t;

  // playback sources
  typedef enum logic [2:0] {
    src_silence,
    src_tone_a,
    src_tone_b,
    src_mic,
    src_decim
  } play_src_t;

  // playback controls from the switches
  typedef struct packed {
    play_src_t  src;
    // freeze the monitor value
    logic       hold;
    // bit 1 left speaker, bit 0 right speaker
    logic [1:0] spk_en;
  } play_cfg_t;

endpackage
